/* logic/wfd_defines.svh */
// channel count, acquisition length, adc and sum widths, event fifo depth
`ifndef WFD_DEFINES_SVH
`define WFD_DEFINES_SVH

// number of digitizer channels on the board
`define WFD_NUM_CHAN 5

`define WFD_ACQ_LEN 8     // samples summed per trigger
`define WFD_ADC_W 12      // raw adc sample width
`define WFD_SUM_W 16      // 8 x 12-bit samples fit in 15 bits

// acquisition-info words held before readout
`define WFD_FIFO_DEPTH 4

`endif

/* logic/wfd_ttc_pkg.sv */
// timing-link command byte views, control opcodes and command union
`default_nettype none

package wfd_ttc_pkg;

  // control opcodes carried in the low nibble
  typedef enum logic [3:0] {
    TTC_NOP       = 4'h0,
    TTC_RESET_NUM = 4'h1   // clear running trigger number
  } ttc_opcode_e;

  typedef struct packed {
    logic       is_trig;    // set for trigger commands
    logic [1:0] spare;
    logic [4:0] trig_type;  // muon fill, laser, pedestal ...
  } ttc_trig_cmd_t;

  typedef struct packed {
    logic        is_trig;   // cleared for control commands
    logic [2:0]  spare;
    ttc_opcode_e opcode;
  } ttc_ctrl_cmd_t;

  // same broadcast byte, two decodings selected by is_trig
  typedef union packed {
    ttc_trig_cmd_t trig;
    ttc_ctrl_cmd_t ctrl;
  } ttc_cmd_u;

endpackage

`default_nettype wire

/* logic/wfd_acq_pkg.sv */
// acquisition state encoding and event-word field widths
`default_nettype none

package wfd_acq_pkg;

  // one-hot controller states
  typedef enum logic [3:0] {
    IDLE           = 4'b0001,
    DELAY          = 4'b0010,  // counting out trig_delay
    FILL           = 4'b0100,  // channels acquiring
    STORE_ACQ_INFO = 4'b1000   // event word to fifo
  } acq_state_e;

  // event word is {zero pad, trig_type, trig_num}
  localparam int ACQ_TYPE_W = 5;
  localparam int ACQ_NUM_W  = 24;

endpackage

`default_nettype wire

/* logic/ttc_trigger_decoder.sv */
// ttc command byte decoder producing trigger pulse, type and running number
`timescale 1ns/1ps
`default_nettype none

module ttc_trigger_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_strobe,  // cmd_byte valid this cycle
  input  wfd_ttc_pkg::ttc_cmd_u cmd_byte,
  output logic                 trigger,     // one-cycle pulse
  output logic [4:0]           trig_type,
  output logic [23:0]          trig_num
);

  import wfd_ttc_pkg::*;

  logic [23:0] num_cnt;  // number for the next trigger
  logic        is_trig;

  assign is_trig = cmd_byte.trig.is_trig;

  // pulse and running count
  always_ff @(posedge clk) begin
    if (reset) begin
      trigger <= 1'b0;
      num_cnt <= '0;
    end else begin
      trigger <= cmd_strobe & is_trig;
      if (cmd_strobe & is_trig) begin
        num_cnt <= num_cnt + 24'd1;  // first trigger goes out as 0
      end else if (cmd_strobe && cmd_byte.ctrl.opcode == TTC_RESET_NUM) begin
        num_cnt <= '0;
      end
    end
  end

  // type and number only meaningful alongside trigger
  always_ff @(posedge clk) begin
    if (cmd_strobe & is_trig) begin
      trig_type <= cmd_byte.trig.trig_type;
      trig_num  <= num_cnt;
    end
  end

  // trigger commands must be spaced by at least one idle strobe cycle
  assert property (@(posedge clk) disable iff (reset) trigger |=> !trigger);

endmodule

`default_nettype wire

/* logic/channel_acq_controller.sv */
// acquisition fsm: trigger delay, channel fill and event-word store
`timescale 1ns/1ps
`default_nettype none
`include "wfd_defines.svh"

module channel_acq_controller (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [`WFD_NUM_CHAN-1:0]            chan_en,     // channels to trigger
  input  logic [31:0]                         trig_delay,  // cycles from trigger to fill
  input  logic                                trigger,
  input  logic [wfd_acq_pkg::ACQ_TYPE_W-1:0]  trig_type,
  input  logic [wfd_acq_pkg::ACQ_NUM_W-1:0]   trig_num,
  output logic                                acq_ready,
  input  logic [`WFD_NUM_CHAN-1:0]            acq_dones,
  output logic [`WFD_NUM_CHAN-1:0]            acq_trig,
  input  logic                                fifo_ready,
  output logic                                fifo_valid,
  output logic [31:0]                         fifo_data
);

  import wfd_acq_pkg::*;

  localparam int PAD_W = 32 - ACQ_TYPE_W - ACQ_NUM_W;

  acq_state_e state;
  acq_state_e nextstate;

  logic [ACQ_TYPE_W-1:0]    acq_trig_type;  // latched at accept
  logic [ACQ_NUM_W-1:0]     acq_trig_num;
  logic [`WFD_NUM_CHAN-1:0] next_acq_trig;
  logic [31:0]              delay_cnt;

  always_comb begin
    nextstate     = state;
    next_acq_trig = '0;
    unique case (state)
      IDLE: begin
        if (trigger) begin
          nextstate = (trig_delay != 32'd0) ? DELAY : FILL;
        end
      end
      DELAY: begin
        if (delay_cnt == trig_delay - 32'd1) nextstate = FILL;  // delay used up
      end
      FILL: begin
        next_acq_trig = chan_en;
        // all enabled channels report done
        if (acq_dones == chan_en) nextstate = STORE_ACQ_INFO;
      end
      STORE_ACQ_INFO: begin
        if (fifo_ready) nextstate = IDLE;  // word taken this cycle
      end
      default: nextstate = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      acq_trig   <= '0;
      fifo_valid <= 1'b0;
    end else begin
      state      <= nextstate;
      acq_trig   <= next_acq_trig;  // one cycle behind fill
      fifo_valid <= (nextstate == STORE_ACQ_INFO);
    end
  end

  // restarts on any trigger, accepted or not
  always_ff @(posedge clk) begin
    if (reset | trigger) delay_cnt <= '0;
    else                 delay_cnt <= delay_cnt + 32'd1;
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && trigger) begin
      acq_trig_type <= trig_type;
      acq_trig_num  <= trig_num;
    end
    if (nextstate == STORE_ACQ_INFO) begin
      fifo_data <= {{PAD_W{1'b0}}, acq_trig_type, acq_trig_num};
    end
  end

  assign acq_ready = (state == IDLE);

  // acq_trig lags fill by one cycle and may overlap the first store cycle
  assert property (@(posedge clk) disable iff (reset)
    (acq_trig != '0) |-> (state == FILL || state == STORE_ACQ_INFO));
  // offered word held steady in store while the fifo is full
  assert property (@(posedge clk) disable iff (reset)
    (fifo_valid && !fifo_ready) |=>
      (fifo_valid && state == STORE_ACQ_INFO && $stable(fifo_data)));

endmodule

`default_nettype wire

/* logic/channel_digitizer.sv */
// single channel triggered adc accumulator with done level and sum output
`timescale 1ns/1ps
`default_nettype none
`include "wfd_defines.svh"

module channel_digitizer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  acq_trig,  // level, high during fill
  input  logic [`WFD_ADC_W-1:0] adc_data,
  output logic                  acq_done,
  output logic [`WFD_SUM_W-1:0] chan_sum
);

  localparam int CNT_W = $clog2(`WFD_ACQ_LEN + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`WFD_ACQ_LEN);

  logic             trig_d;   // acq_trig one cycle late
  logic [CNT_W-1:0] smp_cnt;  // samples taken so far
  logic             first;

  assign first = acq_trig & ~trig_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      trig_d   <= 1'b0;
      smp_cnt  <= '0;
      chan_sum <= '0;
    end else begin
      trig_d <= acq_trig;
      if (first) begin
        // new acquisition starts with this sample
        chan_sum <= `WFD_SUM_W'(adc_data);
        smp_cnt  <= CNT_W'(1);
      end else if (acq_trig && smp_cnt != LAST) begin
        chan_sum <= chan_sum + `WFD_SUM_W'(adc_data);
        smp_cnt  <= smp_cnt + CNT_W'(1);
      end
      // sum stays put after the last sample
    end
  end

  // drops the cycle after acq_trig drops
  assign acq_done = trig_d && (smp_cnt == LAST);

  assert property (@(posedge clk) disable iff (reset) $rose(acq_done) |-> acq_trig);

endmodule

`default_nettype wire

/* logic/acq_event_fifo.sv */
// synchronous circular-buffer fifo for acquisition-info words
`timescale 1ns/1ps
`default_nettype none
`include "wfd_defines.svh"

module acq_event_fifo (
  input  logic        clk,
  input  logic        reset,
  input  logic        wr_en,
  input  logic [31:0] wr_data,
  output logic        full,
  input  logic        rd_en,    // pop head at the edge
  output logic [31:0] rd_data,  // head word, valid when not empty
  output logic        empty
);

  localparam int PTR_W = $clog2(`WFD_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`WFD_FIFO_DEPTH + 1);

  logic [31:0]      mem [`WFD_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // words held
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;  // pop on empty ignored

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + PTR_W'(1);  // depth is a power of two
      if (do_rd) rd_ptr <= rd_ptr + PTR_W'(1);
      case ({do_wr, do_rd})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // none, or both at once
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  assign rd_data = mem[rd_ptr];
  assign full    = (count == CNT_W'(`WFD_FIFO_DEPTH));
  assign empty   = (count == '0);

  // writer has to respect full
  assert property (@(posedge clk) disable iff (reset) wr_en |-> !full);

endmodule

`default_nettype wire

/* logic/wfd_acq_top.sv */
// digitizer board trigger path: decoder, controller, channels and event fifo
`timescale 1ns/1ps
`default_nettype none
`include "wfd_defines.svh"

module wfd_acq_top (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               cmd_strobe,
  input  logic [7:0]                         cmd_byte,
  input  logic [`WFD_NUM_CHAN-1:0]           chan_en,
  input  logic [31:0]                        trig_delay,
  input  logic [`WFD_NUM_CHAN*`WFD_ADC_W-1:0] adc_data,   // channel 0 in low bits
  input  logic                               rd_en,
  output logic                               acq_ready,
  output logic [31:0]                        rd_data,
  output logic                               rd_empty,
  output logic [`WFD_NUM_CHAN*`WFD_SUM_W-1:0] chan_sum
);

  import wfd_acq_pkg::*;

  logic                     trigger;
  logic [ACQ_TYPE_W-1:0]    trig_type;
  logic [ACQ_NUM_W-1:0]     trig_num;
  logic [`WFD_NUM_CHAN-1:0] acq_trig;
  logic [`WFD_NUM_CHAN-1:0] acq_dones;
  logic                     fifo_full;
  logic                     fifo_ready;
  logic                     fifo_valid;
  logic [31:0]              fifo_data;

  assign fifo_ready = ~fifo_full;

  ttc_trigger_decoder decoder_i (
    .clk, .reset, .cmd_strobe, .cmd_byte, .trigger, .trig_type, .trig_num
  );

  channel_acq_controller ctrl_i (
    .clk, .reset, .chan_en, .trig_delay, .trigger, .trig_type, .trig_num,
    .acq_ready, .acq_dones, .acq_trig, .fifo_ready, .fifo_valid, .fifo_data
  );

  for (genvar i = 0; i < `WFD_NUM_CHAN; i++) begin : g_chan
    channel_digitizer chan_i (
      .clk,
      .reset,
      .acq_trig (acq_trig[i]),
      .adc_data (adc_data[i*`WFD_ADC_W +: `WFD_ADC_W]),
      .acq_done (acq_dones[i]),
      .chan_sum (chan_sum[i*`WFD_SUM_W +: `WFD_SUM_W])
    );
  end

  // write happens on valid and ready together
  acq_event_fifo fifo_i (
    .clk,
    .reset,
    .wr_en   (fifo_valid & fifo_ready),
    .wr_data (fifo_data),
    .full    (fifo_full),
    .rd_en,
    .rd_data,
    .empty   (rd_empty)
  );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// testbench clock source and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #10 reset = 1'b0;  // released with the other inputs
  end

endmodule

`default_nettype wire

/* tb/wfd_acq_tb.sv */
// trigger path testbench: stimulus, expected event words and checking assertions
`timescale 1ns/1ps
`default_nettype none
`include "wfd_defines.svh"

module wfd_acq_tb;

  import wfd_ttc_pkg::*;

  localparam int NCH        = `WFD_NUM_CHAN;
  localparam int SW         = `WFD_SUM_W;
  localparam int AW         = `WFD_ADC_W;
  localparam int MAX_DELAY  = 20;
  localparam int MAX_CYCLES = 20 * (MAX_DELAY + 20) + 200;  // 20 triggers at worst delay

  logic              clk;
  logic              reset;
  logic              cmd_strobe;
  logic [7:0]        cmd_byte;
  logic [NCH-1:0]    chan_en;
  logic [31:0]       trig_delay;
  logic [NCH*AW-1:0] adc_data;
  logic              rd_en;
  logic              acq_ready;
  logic [31:0]       rd_data;
  logic              rd_empty;
  logic [NCH*SW-1:0] chan_sum;

  logic [31:0]       exp_word;       // head of scoreboard, for the pop check
  logic              exp_have;
  logic              sum_chk;        // one-cycle strobe to compare sums
  logic [NCH*SW-1:0] exp_sum;
  logic [NCH*SW-1:0] sum_mask;       // enabled channels only
  logic              hold_chk;       // fifo full, acquisition must stall
  logic              trig_accepted;  // strobe is a trigger the fsm takes
  logic              trig_seen;
  int                lat_cnt;        // cycles since accepted trigger strobe
  int                cycle_cnt;
  logic [31:0]       exp_q[$];
  logic [23:0]       exp_num;

  tb_clock_gen clk_gen_i (.clk, .reset);

  wfd_acq_top dut_i (
    .clk, .reset, .cmd_strobe, .cmd_byte, .chan_en, .trig_delay, .adc_data, .rd_en,
    .acq_ready, .rd_data, .rd_empty, .chan_sum
  );

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic tick();
    @(posedge clk);
    #10;  // drive point
  endtask

  task automatic send_cmd(input logic [7:0] b, input logic accept);
    cmd_byte      = b;
    cmd_strobe    = 1'b1;
    trig_accepted = accept;
    trig_seen     = trig_seen | b[7];
    tick();
    cmd_strobe    = 1'b0;
    trig_accepted = 1'b0;
  endtask

  // busy fsm drops it, number still counts it
  task automatic send_lost_trigger();
    send_cmd({3'b100, 5'($urandom_range(31))}, 1'b0);
    exp_num = exp_num + 24'd1;
  endtask

  task automatic start_acq(input logic [NCH-1:0] en, input int dly);
    logic [4:0]    typ;
    logic [AW-1:0] val;
    typ        = 5'($urandom_range(31));
    chan_en    = en;
    trig_delay = 32'(dly);
    sum_mask   = '0;
    for (int i = 0; i < NCH; i++) begin
      val = AW'($urandom);  // held for the whole acquisition
      adc_data[i*AW +: AW] = val;
      exp_sum[i*SW +: SW]  = SW'(val) * SW'(`WFD_ACQ_LEN);
      if (en[i]) sum_mask[i*SW +: SW] = '1;
    end
    exp_q.push_back({3'b000, typ, exp_num});
    exp_num = exp_num + 24'd1;
    send_cmd({3'b100, typ}, 1'b1);
    tick();  // fsm out of IDLE now
  endtask

  task automatic finish_acq();
    while (!acq_ready) tick();
    sum_chk = 1'b1;
    tick();
    sum_chk = 1'b0;
  endtask

  task automatic pop_all();
    while (!rd_empty) begin
      exp_have = (exp_q.size() != 0);
      if (exp_have) exp_word = exp_q.pop_front();
      rd_en = 1'b1;
      tick();
    end
    rd_en    = 1'b0;
    exp_have = 1'b0;
  endtask

  always @(posedge clk) begin
    if (cmd_strobe && trig_accepted) lat_cnt <= 0;
    else                             lat_cnt <= lat_cnt + 1;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", MAX_CYCLES);
      stop_with_failure();
    end
  end

  assert property (@(posedge clk) disable iff (reset) (rd_en && !rd_empty) |-> exp_have)
  else begin
    $display("event fifo held a word that no accepted trigger produced");
    stop_with_failure();
  end

  assert property (@(posedge clk) disable iff (reset)
    (rd_en && !rd_empty && exp_have) |-> (rd_data == exp_word))
  else begin
    $display("mismatch at %0t ns: rd_data got %h expected %h", $time,
      $sampled(rd_data), $sampled(exp_word));
    stop_with_failure();
  end

  assert property (@(posedge clk) disable iff (reset)
    sum_chk |-> ((chan_sum & sum_mask) == (exp_sum & sum_mask)))
  else begin
    $display("mismatch at %0t ns: chan_sum got %h expected %h", $time,
      $sampled(chan_sum) & $sampled(sum_mask), $sampled(exp_sum) & $sampled(sum_mask));
    stop_with_failure();
  end

  // no event word before delay plus fill has run out
  assert property (@(posedge clk) disable iff (reset)
    ($fell(rd_empty) && chan_en != '0) |-> (lat_cnt >= trig_delay + `WFD_ACQ_LEN + 2))
  else begin
    $display("rd_empty fell %0d cycles after the trigger strobe, delay was %0d",
      $sampled(lat_cnt), $sampled(trig_delay));
    stop_with_failure();
  end

  assert property (@(posedge clk) disable iff (reset) hold_chk |-> !acq_ready)
  else begin
    $display("mismatch at %0t ns: acq_ready got 1 expected 0", $time);
    stop_with_failure();
  end

  assert property (@(posedge clk) disable iff (reset) !trig_seen |-> (acq_ready && rd_empty))
  else begin
    $display("mismatch at %0t ns: acq_ready/rd_empty got %b/%b expected 1/1", $time,
      $sampled(acq_ready), $sampled(rd_empty));
    stop_with_failure();
  end

  initial begin
    logic [NCH-1:0] en;
    int             dly;
    void'($urandom(32'hffa6));
    cmd_strobe = 1'b0;
    cmd_byte   = 8'h00;
    chan_en    = '0;
    trig_delay = '0;
    adc_data   = '0;
    rd_en      = 1'b0;
    exp_word   = '0;
    exp_have   = 1'b0;
    sum_chk    = 1'b0;
    exp_sum    = '0;
    sum_mask   = '0;
    hold_chk   = 1'b0;
    trig_accepted = 1'b0;
    trig_seen  = 1'b0;
    exp_num    = '0;
    wait (reset == 1'b0);
    repeat (5) tick();  // quiet stretch after reset

    // one acquisition at a time, fifo drained after each
    for (int n = 0; n < 12; n++) begin
      en  = (n == 3) ? '0 : ((n == 0) ? '1 : NCH'($urandom));
      dly = (n == 1) ? MAX_DELAY : ((n == 0) ? 0 : int'($urandom_range(MAX_DELAY)));
      if (n == 6) begin
        send_cmd({4'h0, TTC_RESET_NUM}, 1'b0);
        exp_num = '0;
        tick();
      end
      if (n == 9) begin
        send_cmd({4'h0, TTC_NOP}, 1'b0);  // number untouched
        tick();
      end
      start_acq(en, dly);
      if (n % 3 == 1) send_lost_trigger();
      finish_acq();
      pop_all();
      tick();
    end

    // fill the fifo unread, the next acquisition must stall in store
    for (int n = 0; n < `WFD_FIFO_DEPTH; n++) begin
      start_acq(NCH'($urandom), int'($urandom_range(MAX_DELAY)));
      finish_acq();
      tick();
    end
    start_acq('1, int'($urandom_range(MAX_DELAY)));
    hold_chk = 1'b1;
    repeat (MAX_DELAY + 25) tick();
    send_lost_trigger();  // arrives during the stall
    repeat (4) tick();
    hold_chk = 1'b0;
    exp_word = exp_q.pop_front();
    exp_have = 1'b1;
    rd_en    = 1'b1;
    tick();
    rd_en    = 1'b0;
    exp_have = 1'b0;
    finish_acq();
    pop_all();

    if (exp_q.size() == 0 && rd_empty) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("event words missing at the end: %0d still expected, fifo empty %b",
        exp_q.size(), rd_empty);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

/* wfd_acq.f */
+incdir+logic
logic/wfd_ttc_pkg.sv
logic/wfd_acq_pkg.sv
logic/ttc_trigger_decoder.sv
logic/channel_acq_controller.sv
logic/channel_digitizer.sv
logic/acq_event_fifo.sv
logic/wfd_acq_top.sv
tb/tb_clock_gen.sv
tb/wfd_acq_tb.sv

/* Bender.yml */
package:
  name: wfd_acq

export_include_dirs:
  - logic

sources:
  - logic/wfd_ttc_pkg.sv
  - logic/wfd_acq_pkg.sv
  - logic/ttc_trigger_decoder.sv
  - logic/channel_acq_controller.sv
  - logic/channel_digitizer.sv
  - logic/acq_event_fifo.sv
  - logic/wfd_acq_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/wfd_acq_tb.sv
